// File: nic_rx_consts.svh
// sizing constants of the receive notification path, included by the RTL and the testbench

`ifndef NIC_RX_CONSTS_SVH
`define NIC_RX_CONSTS_SVH

////////////////////////////////////////
// pointers
////////////////////////////////////////

// hardware and software frame pointers, free running, never wrap in practice
`define NIC_PTR_W 64

////////////////////////////////////////
// host ring
////////////////////////////////////////

// frame slots in the host receive ring
// hw_ptr - sw_ptr stays at or below this value
`define NIC_RING_SLOTS 16

////////////////////////////////////////
// statistics
////////////////////////////////////////

// saturating count of frames dropped on a full ring
`define NIC_DROP_W 16

`endif

// File: nic_rx_types_pkg.sv
// receive-path state types, imported by the ring writer, the irq generator and the checkers
`default_nettype none

package nic_rx_types_pkg;

    ////////////////////////////////////////
    // interrupt generator
    ////////////////////////////////////////

    // irq_idle -> irq_armed -> irq_active, only rst goes back
    typedef enum logic [1:0] {
        irq_idle   = 2'd0, // waiting for host ready
        irq_armed  = 2'd1, // waiting for mac activity
        irq_active = 2'd2  // notifying the host
    } irq_state_t;

    ////////////////////////////////////////
    // receive ring writer
    ////////////////////////////////////////

    // one verdict per frame, taken on its first word
    typedef enum logic [1:0] {
        ring_wait    = 2'd0, // between frames
        ring_store   = 2'd1, // frame accepted into the ring
        ring_discard = 2'd2  // ring full, frame dropped
    } ring_state_t;

endpackage

`default_nettype wire

// File: host_reg_pkg.sv
// host register port types, imported by the register block, the top level and the testbench
`default_nettype none

package host_reg_pkg;

    ////////////////////////////////////////
    // host command opcodes
    ////////////////////////////////////////

    // host_cmd is sampled whenever it is not cmd_nop
    typedef enum logic [2:0] {
        cmd_nop       = 3'd0, // idle cycle
        cmd_wr_sw_ptr = 3'd1, // host_wdata -> software pointer
        cmd_set_ready = 3'd2, // driver ready, sticky
        cmd_rd_hw_ptr = 3'd3, // read hardware pointer
        cmd_rd_drops  = 3'd4  // read drop counter, zero-extended
    } host_cmd_t;

    // codes 5 to 7 are unused and behave like cmd_nop

endpackage

`default_nettype wire

// File: rx_ring_writer.sv
// receive ring writer: counts stored MAC frames, drops frames on a full ring, drives activity
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module rx_ring_writer import nic_rx_types_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire logic                   mac_wr,       // one strobe per data word
    input  wire logic                   mac_last,     // final word of the frame
    input  wire logic [`NIC_PTR_W-1:0]  sw_ptr,       // frames consumed by the host

    output logic      [`NIC_PTR_W-1:0]  hw_ptr,       // frames stored in the ring
    output logic      [`NIC_DROP_W-1:0] drop_count,   // frames dropped, saturating
    output logic                        mac_activity  // stored frame in progress
);

    ring_state_t               ring_state;
    ring_state_t               ring_state_nxt;
    logic [`NIC_PTR_W-1:0]     ring_used;     // occupied slots
    logic                      ring_room;     // at least one slot free
    logic                      first_word;    // word that opens a frame
    logic                      frame_end;     // word that closes a frame
    logic                      store_done;    // accepted frame completes
    logic                      drop_done;     // discarded frame completes

    ////////////////////////////////////////
    // frame classification
    ////////////////////////////////////////

    assign ring_used  = hw_ptr - sw_ptr;
    assign ring_room  = ring_used < `NIC_PTR_W'(`NIC_RING_SLOTS);
    assign first_word = mac_wr && (ring_state == ring_wait);
    assign frame_end  = mac_wr && mac_last;

    // single-word frames open and close on the same word
    assign store_done = frame_end &&
                        (((ring_state == ring_wait) && ring_room) || (ring_state == ring_store));
    assign drop_done  = frame_end &&
                        (((ring_state == ring_wait) && !ring_room) || (ring_state == ring_discard));

    always_comb begin
        ring_state_nxt = ring_state;  // hold by default
        case (ring_state)
            ring_wait: begin
                if (first_word && !mac_last) begin
                    ring_state_nxt = ring_room ? ring_store : ring_discard;
                end
            end
            ring_store: begin
                if (frame_end) begin
                    ring_state_nxt = ring_wait;
                end
            end
            ring_discard: begin
                if (frame_end) begin
                    ring_state_nxt = ring_wait;
                end
            end
            default: begin
                ring_state_nxt = ring_wait;  // unused code
            end
        endcase
    end

    ////////////////////////////////////////
    // pointer, counter, activity
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ring_state   <= ring_wait;
            hw_ptr       <= '0;
            drop_count   <= '0;
            mac_activity <= 1'b0;
        end else begin
            ring_state <= ring_state_nxt;

            if (store_done) begin
                hw_ptr <= hw_ptr + `NIC_PTR_W'(1);  // visible one cycle after mac_last
            end

            if (drop_done && (drop_count != {`NIC_DROP_W{1'b1}})) begin
                drop_count <= drop_count + `NIC_DROP_W'(1);  // stick at all ones
            end

            // high from the cycle after an accepted first word until the cycle after mac_last
            mac_activity <= (first_word && ring_room) ||
                            ((ring_state == ring_store) && !frame_end);
        end
    end

endmodule

`default_nettype wire

// File: host_regs.sv
// host register port: software pointer, driver ready flag and read-back of ring status
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module host_regs import host_reg_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire host_cmd_t              host_cmd,     // sampled when not cmd_nop
    input  wire logic [`NIC_PTR_W-1:0]  host_wdata,   // write payload
    output logic      [`NIC_PTR_W-1:0]  host_rdata,   // read payload
    output logic                        host_rvalid,  // one cycle after a read

    input  wire logic [`NIC_PTR_W-1:0]  hw_ptr,       // from the ring writer
    input  wire logic [`NIC_DROP_W-1:0] drop_count,   // from the ring writer
    output logic      [`NIC_PTR_W-1:0]  sw_ptr,       // frames consumed by the host
    output logic                        hst_rdy       // driver ready, sticky
);

    logic                     wr_sw_ptr;   // software pointer write
    logic                     set_ready;   // ready command
    logic                     rd_req;      // any read command
    logic [`NIC_PTR_W-1:0]    rd_mux;      // selected read source

    ////////////////////////////////////////
    // command decode
    ////////////////////////////////////////

    always_comb begin
        wr_sw_ptr = 1'b0;
        set_ready = 1'b0;
        rd_req    = 1'b0;
        rd_mux    = hw_ptr;
        case (host_cmd)
            cmd_wr_sw_ptr: begin
                wr_sw_ptr = 1'b1;
            end
            cmd_set_ready: begin
                set_ready = 1'b1;
            end
            cmd_rd_hw_ptr: begin
                rd_req = 1'b1;
                rd_mux = hw_ptr;
            end
            cmd_rd_drops: begin
                rd_req = 1'b1;
                rd_mux = {{(`NIC_PTR_W-`NIC_DROP_W){1'b0}}, drop_count};  // zero-extend
            end
            default: begin
                rd_req = 1'b0;  // cmd_nop and unused codes
            end
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sw_ptr      <= '0;
            hst_rdy     <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            if (wr_sw_ptr) begin
                sw_ptr <= host_wdata;
            end
            if (set_ready) begin
                hst_rdy <= 1'b1;  // only rst clears it
            end
            host_rvalid <= rd_req;  // single-cycle pulse
        end
    end

    // read data only meaningful with host_rvalid
    always_ff @(posedge clk) begin
        if (rd_req) begin
            host_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: rx_irq_gen.sv
// receive interrupt generator: waits for host ready and MAC activity, then holds send_irq
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module rx_irq_gen import nic_rx_types_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  mac_activity,  // stored frame in progress
    input  wire logic                  hst_rdy,       // driver ready
    input  wire logic [`NIC_PTR_W-1:0] hw_ptr,        // frames stored
    input  wire logic [`NIC_PTR_W-1:0] sw_ptr,        // frames consumed

    output logic                       send_irq       // interrupt request level
);

    irq_state_t  irq_state;
    logic        act_sync0;   // first synchroniser stage
    logic        act_sync1;   // second stage, used by the FSM
    logic        ptr_pending; // host has frames to consume

    assign ptr_pending = (hw_ptr != sw_ptr);

    ////////////////////////////////////////
    // activity sync and FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            act_sync0 <= 1'b0;
            act_sync1 <= 1'b0;
            send_irq  <= 1'b0;
            irq_state <= irq_idle;
        end else begin
            act_sync0 <= mac_activity;
            act_sync1 <= act_sync0;

            case (irq_state)
                irq_idle: begin
                    if (hst_rdy) begin
                        irq_state <= irq_armed;
                    end
                end
                irq_armed: begin
                    // three cycles after mac_activity rises
                    if (act_sync1) begin
                        send_irq  <= 1'b1;
                        irq_state <= irq_active;
                    end
                end
                irq_active: begin
                    send_irq <= act_sync1 || ptr_pending;  // no way out but rst
                end
                default: begin
                    irq_state <= irq_idle;  // unused code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: nic_rx_irq_top.sv
// receive notification top level: MAC strobes and host register port in, interrupt level out
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module nic_rx_irq_top import host_reg_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // MAC side
    input  wire logic                  mac_wr,       // word strobe
    input  wire logic                  mac_last,     // last word of frame

    // host side
    input  wire host_cmd_t             host_cmd,     // opcode, cmd_nop when idle
    input  wire logic [`NIC_PTR_W-1:0] host_wdata,   // write payload
    output logic      [`NIC_PTR_W-1:0] host_rdata,   // read payload
    output logic                       host_rvalid,  // read answer strobe

    output logic                       send_irq      // interrupt request
);

    logic [`NIC_PTR_W-1:0]  hw_ptr;        // ring writer -> regs, irq
    logic [`NIC_PTR_W-1:0]  sw_ptr;        // regs -> ring writer, irq
    logic [`NIC_DROP_W-1:0] drop_count;    // ring writer -> regs
    logic                   mac_activity;  // ring writer -> irq
    logic                   hst_rdy;       // regs -> irq

    rx_ring_writer u_ring_writer (
        .clk          (clk),
        .rst          (rst),
        .mac_wr       (mac_wr),
        .mac_last     (mac_last),
        .sw_ptr       (sw_ptr),
        .hw_ptr       (hw_ptr),
        .drop_count   (drop_count),
        .mac_activity (mac_activity)
    );

    host_regs u_host_regs (
        .clk         (clk),
        .rst         (rst),
        .host_cmd    (host_cmd),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .hw_ptr      (hw_ptr),
        .drop_count  (drop_count),
        .sw_ptr      (sw_ptr),
        .hst_rdy     (hst_rdy)
    );

    rx_irq_gen u_irq_gen (
        .clk          (clk),
        .rst          (rst),
        .mac_activity (mac_activity),
        .hst_rdy      (hst_rdy),
        .hw_ptr       (hw_ptr),
        .sw_ptr       (sw_ptr),
        .send_irq     (send_irq)
    );

endmodule

`default_nettype wire

// File: nic_rx_irq_assert.sv
// concurrent checks on the irq generator and the ring writer, bound into both blocks
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module nic_rx_irq_assert import nic_rx_types_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire irq_state_t            irq_state,     // irq_idle when bound in the ring writer
    input  wire logic                  send_irq,
    input  wire ring_state_t           ring_state,    // ring_wait when bound in the irq generator
    input  wire logic                  mac_activity,
    input  wire logic [`NIC_PTR_W-1:0] hw_ptr,
    input  wire logic [`NIC_PTR_W-1:0] sw_ptr
);

    int fail_count = 0;  // failed assertions so far

    // no notification before the driver is ready
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (irq_state == irq_idle) |-> !send_irq)
        else begin
            $error("send_irq high while waiting for host ready");
            fail_count++;
        end

    // armed for good once active
    active_sticky: assert property (@(posedge clk) disable iff (rst)
        (irq_state == irq_active) |=> (irq_state == irq_active))
        else begin
            $error("irq FSM left irq_active without reset");
            fail_count++;
        end

    ring_bound: assert property (@(posedge clk) disable iff (rst)
        (hw_ptr - sw_ptr) <= `NIC_PTR_W'(`NIC_RING_SLOTS))
        else begin
            $error("hw_ptr ahead of sw_ptr by more than the ring size");
            fail_count++;
        end

    // dropped frames stay invisible to the irq path
    discard_silent: assert property (@(posedge clk) disable iff (rst)
        (ring_state == ring_discard) |-> !mac_activity)
        else begin
            $error("mac_activity high during a dropped frame");
            fail_count++;
        end

endmodule

bind rx_irq_gen nic_rx_irq_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .irq_state    (irq_state),
    .send_irq     (send_irq),
    .ring_state   (nic_rx_types_pkg::ring_wait),
    .mac_activity (mac_activity),
    .hw_ptr       (hw_ptr),
    .sw_ptr       (sw_ptr)
);

bind rx_ring_writer nic_rx_irq_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .irq_state    (nic_rx_types_pkg::irq_idle),
    .send_irq     (1'b0),
    .ring_state   (ring_state),
    .mac_activity (mac_activity),
    .hw_ptr       (hw_ptr),
    .sw_ptr       (sw_ptr)
);

`default_nettype wire

// File: tb_nic_rx_irq.sv
// testbench for the receive notification top: random frames and host commands against a model
`timescale 1ns/100ps
`default_nettype none

`include "nic_rx_consts.svh"

module tb_nic_rx_irq import host_reg_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 8;
    localparam int FRAME_CYC  = 20;  // 8 words, idle, gap, read-back
    localparam int N_FRAMES   = 4 + 3 + 6 + (`NIC_RING_SLOTS + 8) + 6;
    localparam int LIMIT_CYC  = RST_CYCLES + N_FRAMES * FRAME_CYC + 300;  // hold windows, margin

    logic                   clk;
    logic                   rst;
    logic                   mac_wr;
    logic                   mac_last;
    host_cmd_t              host_cmd;
    logic [`NIC_PTR_W-1:0]  host_wdata;
    logic [`NIC_PTR_W-1:0]  host_rdata;
    logic                   host_rvalid;
    logic                   send_irq;

    logic [`NIC_PTR_W-1:0]  hw_m;          // model frames stored
    logic [`NIC_PTR_W-1:0]  sw_m;          // model frames consumed
    logic [`NIC_DROP_W-1:0] drops_m;       // model frames dropped
    logic                   ready_m;       // model driver ready
    logic                   quiet_chk;     // send_irq must stay low
    string                  test_name;
    int                     errors;
    int                     errors_at;     // count at test start
    int                     tests_run;
    int                     tests_failed;

    nic_rx_irq_top DUT (
        .clk         (clk),
        .rst         (rst),
        .mac_wr      (mac_wr),
        .mac_last    (mac_last),
        .host_cmd    (host_cmd),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .send_irq    (send_irq)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // check and report helpers
    ////////////////////////////////////////

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_at) begin
            tests_failed++;
            $display("test %s: fail, %0d errors", test_name, errors - errors_at);
        end else begin
            $display("test %s: pass", test_name);
        end
    endtask

    // before ready nothing may reach the host
    always @(negedge clk) begin
        if (quiet_chk && !ready_m) begin
            check_val("send_irq", 1'b0, send_irq);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    function automatic int rand_len();
        return 1 + int'($urandom % 8);  // 1 to 8 words
    endfunction

    // one frame, verdict taken at the first word like the ring writer
    task automatic send_frame(input int len);
        int   w;
        logic take;
        take = (hw_m - sw_m) < `NIC_RING_SLOTS;
        for (w = 0; w < len; w++) begin
            @(posedge clk);
            mac_wr   <= 1'b1;
            mac_last <= (w == len - 1);
        end
        @(posedge clk);
        mac_wr   <= 1'b0;
        mac_last <= 1'b0;
        if (take) begin
            hw_m = hw_m + 1;
        end else if (drops_m != {`NIC_DROP_W{1'b1}}) begin
            drops_m = drops_m + 1;  // saturating
        end
    endtask

    task automatic host_write(input host_cmd_t cmd, input logic [`NIC_PTR_W-1:0] data);
        @(posedge clk);
        host_cmd   <= cmd;
        host_wdata <= data;
        @(posedge clk);
        host_cmd   <= cmd_nop;
    endtask

    // answer is due exactly one cycle after the command
    task automatic host_read(input host_cmd_t cmd, output logic [`NIC_PTR_W-1:0] data);
        @(posedge clk);
        host_cmd <= cmd;
        @(posedge clk);
        host_cmd <= cmd_nop;
        @(negedge clk);
        data = host_rdata;
        if (host_rvalid !== 1'b1) begin
            errors++;
            $display("%s: host_rvalid missing one cycle after a read", test_name);
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int   k;
        logic seen;
        seen = 1'b0;
        for (k = 0; k < limit && !seen; k++) begin
            @(negedge clk);
            seen = (send_irq === level);
        end
        if (!seen) begin
            errors++;
            $display("%s: send_irq did not reach %0d within %0d cycles", test_name, level, limit);
        end
    endtask

    task automatic hold_irq(input logic level, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_val("send_irq", level, send_irq);
        end
    endtask

    task automatic frame_checked(input int len);
        logic [`NIC_PTR_W-1:0] rd;
        send_frame(len);
        host_read(cmd_rd_hw_ptr, rd);
        check_val("hw_ptr", hw_m, rd);
        repeat ($urandom % 4) @(posedge clk);  // idle gap
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int                    i;
        int                    n;
        int                    asrt;
        logic [`NIC_PTR_W-1:0] rd;
        void'($urandom(54196));
        rst          = 1'b1;
        mac_wr       = 1'b0;
        mac_last     = 1'b0;
        host_cmd     = cmd_nop;
        host_wdata   = '0;
        hw_m         = '0;
        sw_m         = '0;
        drops_m      = '0;
        ready_m      = 1'b0;
        quiet_chk    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        start_test("no_irq_before_ready");
        quiet_chk = 1'b1;
        for (i = 0; i < 4; i++) begin
            send_frame(rand_len());
            repeat ($urandom % 4) @(posedge clk);
        end
        repeat (6) @(posedge clk);  // let the synchroniser drain
        quiet_chk = 1'b0;
        end_test();

        start_test("irq_after_ready");
        host_write(cmd_set_ready, '0);
        ready_m = 1'b1;
        repeat (3) @(posedge clk);  // idle -> armed
        for (i = 0; i < 3; i++) begin
            fork
                send_frame(rand_len());
                begin
                    @(posedge clk);  // same edge as the first word
                    wait_irq(1'b1, 5);
                end
            join
            hold_irq(hw_m != sw_m, 5);
        end
        end_test();

        start_test("hw_ptr_readback");
        for (i = 0; i < 6; i++) begin
            frame_checked(rand_len());
        end
        end_test();

        start_test("irq_clear_on_sw_ptr");
        repeat (6) @(posedge clk);  // no frame in flight
        host_write(cmd_wr_sw_ptr, hw_m);
        sw_m = hw_m;
        wait_irq(1'b0, 5);
        hold_irq(1'b0, 12);
        end_test();

        start_test("drop_on_full_ring");
        n = `NIC_RING_SLOTS + 4 + int'($urandom % 5);
        for (i = 0; i < n; i++) begin
            frame_checked(rand_len());
        end
        host_read(cmd_rd_drops, rd);
        check_val("drop_count", drops_m, rd);
        host_read(cmd_rd_hw_ptr, rd);
        check_val("hw_ptr at full ring", sw_m + `NIC_RING_SLOTS, rd);
        end_test();

        start_test("store_after_sw_advance");
        sw_m = sw_m + 1 + ($urandom % `NIC_RING_SLOTS);  // frees 1 to 16 slots
        host_write(cmd_wr_sw_ptr, sw_m);
        for (i = 0; i < 6; i++) begin
            frame_checked(rand_len());
        end
        host_read(cmd_rd_drops, rd);
        check_val("drop_count", drops_m, rd);
        end_test();

        asrt = DUT.u_irq_gen.u_assert.fail_count + DUT.u_ring_writer.u_assert.fail_count;
        $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run limit from the frame budget of all tests
    initial begin
        #(LIMIT_CYC * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: nic_rx_irq_top.f
+incdir+.
nic_rx_types_pkg.sv
host_reg_pkg.sv
rx_ring_writer.sv
host_regs.sv
rx_irq_gen.sv
nic_rx_irq_top.sv
nic_rx_irq_assert.sv
tb_nic_rx_irq.sv

// File: Bender.yml
package:
  name: nic_rx_irq

export_include_dirs:
  - .

sources:
  - nic_rx_types_pkg.sv
  - host_reg_pkg.sv
  - rx_ring_writer.sv
  - host_regs.sv
  - rx_irq_gen.sv
  - nic_rx_irq_top.sv
  - target: test
    files:
      - nic_rx_irq_assert.sv
      - tb_nic_rx_irq.sv
